//--- Makefile
# Verilator build and run for the minimig glue core

VERILATOR ?= verilator
TOP       := tb_minimig_glue
FILELIST  := project.f
FLAGS     := --timing --assert
OBJ_DIR   := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only when the pass line shows up in the output
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- hdl/addr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module addr_decoder import glue_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  logic     sys_rst,	// from the reset sequencer
	input  cpu_req_t cpu,
	input  mem_cfg_t mem_cfg,
	output dev_sel_t sel
);

	logic [ADDR_W:0]     baddr;		// byte address, A0 always zero
	logic [NUM_CHIP-1:0] chip_hit;
	logic [NUM_SLOW-1:0] slow_hit;
	logic                kick_hit;
	logic                kick_ovl;	// chip block 0 read redirected to rom
	logic                cia_page;
	logic                ovl;		// kickstart overlay

	assign baddr = {cpu.addr, 1'b0};

	// ------------------------------------------------------------------------
	// ram regions
	// ------------------------------------------------------------------------

	// chip block k exists up to chip_size
	always_comb begin
		chip_hit = '0;
		for (int k = 0; k < NUM_CHIP; k++) begin
			chip_hit[k] = (baddr[23:21] == CHIP_HI)
				&& (baddr[20:19] == 2'(k))
				&& (k <= int'(mem_cfg.chip_size));
		end
	end

	// slow block k exists below slow_size
	always_comb begin
		slow_hit = '0;
		for (int k = 0; k < NUM_SLOW; k++) begin
			slow_hit[k] = (baddr[23:21] == SLOW_HI)
				&& (baddr[20:19] == 2'(k))
				&& (k < int'(mem_cfg.slow_size));
		end
	end

	assign kick_hit = (baddr[23:19] == KICK_HI);	// top 512K

	// boot vectors come from rom while overlay is on but writes still hit chip ram
	assign kick_ovl = ovl && cpu.rd && chip_hit[0];

	// ------------------------------------------------------------------------
	// io regions
	// ------------------------------------------------------------------------
	assign cia_page = (baddr[23:16] == CIA_PAGE);

	always_comb begin
		sel           = '0;
		sel.chip      = {chip_hit[NUM_CHIP-1:1], chip_hit[0] & ~kick_ovl};
		sel.slow      = slow_hit;
		sel.kick      = kick_hit | kick_ovl;
		sel.cia_a     = cia_page & ~baddr[12];	// odd byte cia
		sel.cia_b     = cia_page & ~baddr[13];	// even byte cia
		sel.custom    = (baddr[23:12] == CUSTOM_PAGE);
		sel.rtc       = (baddr[23:16] == RTC_PAGE);
		sel.ram_wr_ok = ~(kick_hit | kick_ovl);	// rom is read only
	end

	// ------------------------------------------------------------------------
	// overlay flag
	// ------------------------------------------------------------------------

	// the boot code clears it through the cia a port register
	always_ff @(posedge clk) begin
		if (reset || sys_rst) begin
			ovl <= 1'b1;
		end else if (sel.cia_a && (cpu.hwr || cpu.lwr)) begin
			ovl <= 1'b0;	// any write to cia a
		end
	end

endmodule

`default_nettype wire

//--- hdl/bank_mapper.sv
`timescale 1ns/1ps
`default_nettype none

module bank_mapper import glue_pkg::*; (
	input  cpu_req_t cpu,
	input  dev_sel_t sel,
	output ram_req_t ram
);

	logic [NUM_BANKS-1:0] bank;
	logic                 any_bank;
	logic                 wr_en;

	// ------------------------------------------------------------------------
	// bank select
	// ------------------------------------------------------------------------

	// bit order chip 0..3 then slow 0..2 then rom on top
	assign bank = {sel.kick, sel.slow, sel.chip};

	assign any_bank = |bank;
	assign wr_en    = any_bank & sel.ram_wr_ok;	// no writes into rom

	// ------------------------------------------------------------------------
	// request to the ram controller
	// ------------------------------------------------------------------------
	always_comb begin
		ram      = '0;
		ram.bank = bank;
		ram.addr = cpu.addr[BANK_AW-1:0];	// word offset inside 512K
		ram.rd   = cpu.rd & any_bank;
		ram.hwr  = cpu.hwr & wr_en;
		ram.lwr  = cpu.lwr & wr_en;
	end

endmodule

`default_nettype wire

//--- hdl/cpu_data_mux.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_data_mux import glue_pkg::*; (
	input  cpu_req_t          cpu,
	input  dev_sel_t          sel,
	input  logic [DATA_W-1:0] ram_rdata,
	input  logic [7:0]        cia_a_rdata,
	input  logic [7:0]        cia_b_rdata,
	input  logic [DATA_W-1:0] custom_rdata,
	input  logic [RTC_W-1:0]  rtc,
	output logic [DATA_W-1:0] cpu_rdata
);

	logic [ADDR_W:0]   baddr;
	logic              any_bank;
	logic [3:0]        rtc_nib;
	logic [DATA_W-1:0] ram_part;
	logic [DATA_W-1:0] cia_part;
	logic [DATA_W-1:0] custom_part;
	logic [DATA_W-1:0] rtc_part;

	assign baddr    = {cpu.addr, 1'b0};
	assign any_bank = |{sel.kick, sel.slow, sel.chip};

	// one nibble per longword of the rtc space
	assign rtc_nib = rtc[{baddr[5:2], 2'b00} +: 4];

	// each source only drives while its select is up
	assign ram_part    = ram_rdata & {DATA_W{any_bank}};
	assign cia_part    = ({{(DATA_W-8){1'b0}}, cia_a_rdata} & {DATA_W{sel.cia_a}})
		| ({cia_b_rdata, {(DATA_W-8){1'b0}}} & {DATA_W{sel.cia_b}});
	assign custom_part = custom_rdata & {DATA_W{sel.custom}};
	assign rtc_part    = {{(DATA_W-4){1'b0}}, rtc_nib} & {DATA_W{sel.rtc}};

	// wired-or read bus that stays quiet outside read cycles
	assign cpu_rdata = cpu.rd ? (ram_part | cia_part | custom_part | rtc_part) : '0;

endmodule

`default_nettype wire

//--- hdl/glue_pkg.sv
`default_nettype none

package glue_pkg;

	// ------------------------------------------------------------------------
	// bus and bank widths
	// ------------------------------------------------------------------------
	localparam int ADDR_W    = 23;	// cpu word address A23..A1
	localparam int DATA_W    = 16;
	localparam int NUM_BANKS = 8;	// 4 chip + 3 slow + kickstart
	localparam int RTC_W     = 64;
	localparam int BANK_AW   = 18;	// words in one 512 KB bank
	localparam int NUM_CHIP  = 4;
	localparam int NUM_SLOW  = 3;

	// ------------------------------------------------------------------------
	// memory map in byte address bits
	// ------------------------------------------------------------------------
	localparam logic [2:0]  CHIP_HI     = 3'b000;	// A23..A21 for 0x000000 up to 2 MB
	localparam logic [2:0]  SLOW_HI     = 3'b110;	// A23..A21 for 0xC00000 up
	localparam logic [4:0]  KICK_HI     = 5'b11111;	// A23..A19 for 0xF80000 to 0xFFFFFF
	localparam logic [7:0]  CIA_PAGE    = 8'hBF;	// A23..A16
	localparam logic [7:0]  RTC_PAGE    = 8'hDC;	// A23..A16
	localparam logic [11:0] CUSTOM_PAGE = 12'hDFF;	// A23..A12

	// one cpu bus cycle as seen by the glue
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic              rd;
		logic              hwr;	// upper byte write
		logic              lwr;	// lower byte write
	} cpu_req_t;

	typedef struct packed {
		logic [1:0] chip_size;	// 0 is 512 KB up to 3 for 2 MB
		logic [1:0] slow_size;	// number of 512 KB slow blocks
	} mem_cfg_t;

	// device selects from the address decoder
	typedef struct packed {
		logic [NUM_CHIP-1:0] chip;
		logic [NUM_SLOW-1:0] slow;
		logic                kick;
		logic                cia_a;
		logic                cia_b;
		logic                custom;
		logic                rtc;
		logic                ram_wr_ok;	// low for rom
	} dev_sel_t;

	typedef struct packed {
		logic [NUM_BANKS-1:0] bank;	// one-hot
		logic [BANK_AW-1:0]   addr;
		logic                 rd;
		logic                 hwr;
		logic                 lwr;
	} ram_req_t;

	typedef enum logic {RST_HOLD, RST_RUN} rst_state_t;

endpackage

`default_nettype wire

//--- hdl/irq_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module irq_encoder (
	input  logic       clk,
	input  logic       reset,
	input  logic [5:0] int_req,	// bit i is level i+1
	input  logic       freeze,	// cartridge freeze button strobe
	input  logic       nmi_ack,
	output logic [2:0] ipl_n
);

	logic       frz;		// pending level 7
	logic       frz_next;
	logic [2:0] level;

	// highest active level wins
	always_comb begin
		level = 3'd0;
		for (int i = 0; i < 6; i++) begin
			if (int_req[i]) begin
				level = 3'(i + 1);
			end
		end
	end

	// freeze strobe beats an ack in the same cycle
	assign frz_next = freeze | (frz & ~nmi_ack);

	// ------------------------------------------------------------------------
	// registered ipl lines
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			frz   <= 1'b0;
			ipl_n <= 3'b111;	// no request
		end else begin
			frz   <= frz_next;
			ipl_n <= frz_next ? 3'b000 : ~level;	// nmi
		end
	end

endmodule

`default_nettype wire

//--- hdl/minimig_glue.sv
`timescale 1ns/1ps
`default_nettype none

module minimig_glue import glue_pkg::*; #(
	parameter int FRAME_COUNT = 4	// passed on to the reset sequencer
) (
	input  logic              clk,
	input  logic              reset,
	// cpu cycle and memory setup
	input  cpu_req_t          cpu,
	input  mem_cfg_t          mem_cfg,
	// read data from ram and peripherals
	input  logic [DATA_W-1:0] ram_rdata,
	input  logic [7:0]        cia_a_rdata,
	input  logic [7:0]        cia_b_rdata,
	input  logic [DATA_W-1:0] custom_rdata,
	input  logic [RTC_W-1:0]  rtc,
	// interrupt sources
	input  logic [5:0]        int_req,
	input  logic              freeze,
	input  logic              nmi_ack,
	// reset sources
	input  logic              sof,
	input  logic              mrst,
	input  logic              cpurst,
	input  logic              cpu_reset_in_n,
	output dev_sel_t          sel,
	output ram_req_t          ram,
	output logic [DATA_W-1:0] cpu_rdata,
	output logic [2:0]        ipl_n,
	output logic              cpu_reset_n,
	output logic              sys_rst_out
);

	logic sys_rst;	// sequencer hold that also rearms the overlay

	// ------------------------------------------------------------------------
	// cpu side decode and data
	// ------------------------------------------------------------------------
	addr_decoder u_addr_decoder (
		.clk     (clk),
		.reset   (reset),
		.sys_rst (sys_rst),
		.cpu     (cpu),
		.mem_cfg (mem_cfg),
		.sel     (sel)
	);

	bank_mapper u_bank_mapper (
		.cpu (cpu),
		.sel (sel),
		.ram (ram)
	);

	cpu_data_mux u_cpu_data_mux (
		.cpu          (cpu),
		.sel          (sel),
		.ram_rdata    (ram_rdata),
		.cia_a_rdata  (cia_a_rdata),
		.cia_b_rdata  (cia_b_rdata),
		.custom_rdata (custom_rdata),
		.rtc          (rtc),
		.cpu_rdata    (cpu_rdata)
	);

	// ------------------------------------------------------------------------
	// interrupts and reset
	// ------------------------------------------------------------------------
	irq_encoder u_irq_encoder (
		.clk     (clk),
		.reset   (reset),
		.int_req (int_req),
		.freeze  (freeze),
		.nmi_ack (nmi_ack),
		.ipl_n   (ipl_n)
	);

	sys_reset #(
		.FRAME_COUNT (FRAME_COUNT)
	) u_sys_reset (
		.clk            (clk),
		.reset          (reset),
		.mrst           (mrst),
		.cpurst         (cpurst),
		.sof            (sof),
		.cpu_reset_in_n (cpu_reset_in_n),
		.sys_rst        (sys_rst),
		.sys_rst_out    (sys_rst_out),
		.cpu_reset_n    (cpu_reset_n)
	);

endmodule

`default_nettype wire

//--- hdl/sys_reset.sv
`timescale 1ns/1ps
`default_nettype none

module sys_reset import glue_pkg::*; #(
	parameter int FRAME_COUNT = 4	// frames held in reset
) (
	input  logic clk,
	input  logic reset,
	input  logic mrst,		// user or host reset request
	input  logic cpurst,		// cpu only reset
	input  logic sof,		// start of frame strobe
	input  logic cpu_reset_in_n,	// reset instruction from the cpu
	output logic sys_rst,
	output logic sys_rst_out,
	output logic cpu_reset_n
);

	localparam int CNT_W = $clog2(FRAME_COUNT + 1);

	rst_state_t       state;
	logic [CNT_W-1:0] cnt;		// frames still to wait
	logic             rst_sync;	// first sync stage

	// ------------------------------------------------------------------------
	// frame counted system reset
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset || mrst) begin
			state <= RST_HOLD;
			cnt   <= CNT_W'(FRAME_COUNT);
		end else begin
			case (state)
				RST_HOLD: begin
					if (sof) begin
						cnt <= cnt - 1'b1;
						if (cnt <= CNT_W'(1)) begin
							state <= RST_RUN;	// last frame done
							cnt   <= '0;
						end
					end
				end
				RST_RUN: begin
					state <= RST_RUN;	// stays until reset or mrst
				end
				default: begin
					state <= RST_HOLD;
				end
			endcase
		end
	end

	assign sys_rst     = (state == RST_HOLD);
	assign sys_rst_out = sys_rst | ~cpu_reset_in_n;	// status to the host side

	// ------------------------------------------------------------------------
	// cpu reset through two flops
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			rst_sync    <= 1'b0;
			cpu_reset_n <= 1'b0;
		end else begin
			rst_sync    <= ~(cpurst | sys_rst);
			cpu_reset_n <= rst_sync;
		end
	end

endmodule

`default_nettype wire

//--- project.f
hdl/glue_pkg.sv
hdl/addr_decoder.sv
hdl/bank_mapper.sv
hdl/cpu_data_mux.sv
hdl/irq_encoder.sv
hdl/sys_reset.sv
hdl/minimig_glue.sv
test/tb_minimig_glue.sv

//--- test/tb_minimig_glue.sv
`timescale 1ns/1ps
`default_nettype none

module tb_minimig_glue import glue_pkg::*; ();

	localparam int          CLK_PERIOD  = 8;
	localparam int unsigned FRAME_COUNT = 4;
	localparam int unsigned PER_CFG     = 24;	// decode cycles per mem_cfg value
	localparam int unsigned READ_CYC    = 300;
	localparam int unsigned TOTAL_CYC   = 4 + 100 + 10 + 16 * PER_CFG + READ_CYC + 160;

	logic              clk;
	logic              reset;
	cpu_req_t          cpu;
	mem_cfg_t          mem_cfg;
	logic [DATA_W-1:0] ram_rdata;
	logic [7:0]        cia_a_rdata;
	logic [7:0]        cia_b_rdata;
	logic [DATA_W-1:0] custom_rdata;
	logic [RTC_W-1:0]  rtc;
	logic [5:0]        int_req;
	logic              freeze;
	logic              nmi_ack;
	logic              sof;
	logic              mrst;
	logic              cpurst;
	logic              cpu_reset_in_n;
	dev_sel_t          sel;
	ram_req_t          ram;
	logic [DATA_W-1:0] cpu_rdata;
	logic [2:0]        ipl_n;
	logic              cpu_reset_n;
	logic              sys_rst_out;

	// reference model state
	int unsigned       sofs_seen;	// frames counted since the last reset request
	logic              hold_m;
	logic              run_src;	// cpu may run before the two flop delay
	logic [1:0]        run_dly;	// run_src one and two cycles back
	logic              ovl_m;
	logic              frz_m;
	logic [2:0]        ipl_m;
	dev_sel_t          exp_sel;
	ram_req_t          exp_ram;
	logic [DATA_W-1:0] exp_rdata;

	minimig_glue #(
		.FRAME_COUNT (FRAME_COUNT)
	) u_dut (
		.clk            (clk),
		.reset          (reset),
		.cpu            (cpu),
		.mem_cfg        (mem_cfg),
		.ram_rdata      (ram_rdata),
		.cia_a_rdata    (cia_a_rdata),
		.cia_b_rdata    (cia_b_rdata),
		.custom_rdata   (custom_rdata),
		.rtc            (rtc),
		.int_req        (int_req),
		.freeze         (freeze),
		.nmi_ack        (nmi_ack),
		.sof            (sof),
		.mrst           (mrst),
		.cpurst         (cpurst),
		.cpu_reset_in_n (cpu_reset_in_n),
		.sel            (sel),
		.ram            (ram),
		.cpu_rdata      (cpu_rdata),
		.ipl_n          (ipl_n),
		.cpu_reset_n    (cpu_reset_n),
		.sys_rst_out    (sys_rst_out)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ------------------------------------------------------------------------
	// failure reporting
	// ------------------------------------------------------------------------
	task automatic abort_run();
		$display("TEST FAILED");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		$display("MISMATCH at %0t: %s is %0h, expected %0h", $time, name, got, exp);
		abort_run();
	endtask

	task automatic stop_on_error(input string why);
		$display("ERROR at %0t: %s", $time, why);
		abort_run();
	endtask

	// ------------------------------------------------------------------------
	// reference model from the memory map rules
	// ------------------------------------------------------------------------
	function automatic dev_sel_t decode_ref(cpu_req_t c, mem_cfg_t m, logic overlay);
		dev_sel_t    s;
		logic [23:0] ba;
		int unsigned b;
		int unsigned blk;
		s   = '0;
		ba  = {c.addr, 1'b0};
		b   = {8'h00, ba};
		blk = b / 32'h80000;	// 512K block number
		if (b < ({30'd0, m.chip_size} + 32'd1) * 32'h80000) begin
			s.chip[blk[1:0]] = 1'b1;
		end
		if (b >= 32'hC00000 && b < 32'hC00000 + {30'd0, m.slow_size} * 32'h80000) begin
			blk = (b - 32'hC00000) / 32'h80000;
			s.slow[blk[1:0]] = 1'b1;
		end
		s.kick = (b >= 32'hF80000);
		if (overlay && c.rd && s.chip[0]) begin	// boot rom shadows chip ram
			s.chip[0] = 1'b0;
			s.kick    = 1'b1;
		end
		if (b >= 32'hBF0000 && b <= 32'hBFFFFF) begin
			s.cia_a = ~ba[12];
			s.cia_b = ~ba[13];
		end
		s.rtc       = (b >= 32'hDC0000 && b <= 32'hDCFFFF);
		s.custom    = (b >= 32'hDFF000 && b <= 32'hDFFFFF);
		s.ram_wr_ok = ~s.kick;
		return s;
	endfunction

	function automatic ram_req_t map_ref(cpu_req_t c, dev_sel_t s);
		ram_req_t r;
		logic     hit;
		r      = '0;
		r.bank = {s.kick, s.slow, s.chip};	// chip, slow, rom from bit 0 up
		hit    = |r.bank;
		r.addr = c.addr[BANK_AW-1:0];
		r.rd   = c.rd & hit;
		r.hwr  = c.hwr & hit & ~s.kick;
		r.lwr  = c.lwr & hit & ~s.kick;
		return r;
	endfunction

	function automatic logic [DATA_W-1:0] read_ref(cpu_req_t c, dev_sel_t s,
			logic [DATA_W-1:0] ram_d, logic [7:0] a_d, logic [7:0] b_d,
			logic [DATA_W-1:0] cust_d, logic [RTC_W-1:0] rtc_v);
		logic [DATA_W-1:0] d;
		logic [23:0]       ba;
		logic [6:0]        sh;
		d  = '0;
		ba = {c.addr, 1'b0};
		sh = {1'b0, ba[5:2], 2'b00};	// nibble index times four
		if (c.rd) begin
			if (|{s.kick, s.slow, s.chip}) d |= ram_d;
			if (s.cia_a) d |= {8'h00, a_d};
			if (s.cia_b) d |= {b_d, 8'h00};
			if (s.custom) d |= cust_d;
			if (s.rtc) d |= {12'h000, 4'(rtc_v >> sh)};
		end
		return d;
	endfunction

	function automatic logic [2:0] level_ref(logic [5:0] req);
		logic [2:0] code;
		code = 3'b111;	// idle
		for (int lv = 1; lv <= 6; lv++) begin
			if (req[lv-1]) code = ~3'(lv);
		end
		return code;
	endfunction

	assign hold_m  = (sofs_seen < FRAME_COUNT);
	assign run_src = ~(cpurst | hold_m);

	always_comb begin
		exp_sel   = decode_ref(cpu, mem_cfg, ovl_m);
		exp_ram   = map_ref(cpu, exp_sel);
		exp_rdata = read_ref(cpu, exp_sel, ram_rdata, cia_a_rdata, cia_b_rdata,
			custom_rdata, rtc);
	end

	always_ff @(posedge clk) begin
		if (reset || mrst) begin
			sofs_seen <= 0;
		end else if (hold_m && sof) begin
			sofs_seen <= sofs_seen + 1;	// sof in run state is ignored
		end
		run_dly <= {run_dly[0], run_src};
		if (reset || hold_m) begin
			ovl_m <= 1'b1;
		end else if (exp_sel.cia_a && (cpu.hwr || cpu.lwr)) begin
			ovl_m <= 1'b0;
		end
		if (reset) begin
			frz_m <= 1'b0;
			ipl_m <= 3'b111;
		end else if (freeze) begin
			frz_m <= 1'b1;
			ipl_m <= 3'b000;
		end else if (frz_m && !nmi_ack) begin
			ipl_m <= 3'b000;	// level 7 held
		end else begin
			frz_m <= 1'b0;
			ipl_m <= level_ref(int_req);
		end
	end

	// ------------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------------
	a_sel: assert property (@(posedge clk) disable iff (reset) sel == exp_sel)
		else report_mismatch("sel", 64'($sampled(sel)), 64'($sampled(exp_sel)));
	a_ram: assert property (@(posedge clk) disable iff (reset) ram == exp_ram)
		else report_mismatch("ram", 64'($sampled(ram)), 64'($sampled(exp_ram)));
	a_rdata: assert property (@(posedge clk) disable iff (reset) cpu_rdata == exp_rdata)
		else report_mismatch("cpu_rdata", 64'($sampled(cpu_rdata)),
			64'($sampled(exp_rdata)));
	a_ipl: assert property (@(posedge clk) disable iff (reset) ipl_n == ipl_m)
		else report_mismatch("ipl_n", 64'($sampled(ipl_n)), 64'($sampled(ipl_m)));
	a_rst_out: assert property (@(posedge clk) disable iff (reset)
		sys_rst_out == (hold_m | ~cpu_reset_in_n))
		else report_mismatch("sys_rst_out", 64'($sampled(sys_rst_out)),
			64'($sampled(hold_m | ~cpu_reset_in_n)));
	a_cpu_rst: assert property (@(posedge clk) disable iff (reset)
		cpu_reset_n == run_dly[1])	// exactly two flops
		else report_mismatch("cpu_reset_n", 64'($sampled(cpu_reset_n)),
			64'($sampled(run_dly[1])));
	a_rom_wp: assert property (@(posedge clk) disable iff (reset)
		ram.bank[7] |-> !(ram.hwr || ram.lwr))
		else stop_on_error("a write strobe reached the kickstart rom bank");
	a_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(ram.bank))
		else stop_on_error("more than one ram bank selected at once");

	// ------------------------------------------------------------------------
	// stimulus helpers
	// ------------------------------------------------------------------------
	function automatic logic [ADDR_W-1:0] word_of(logic [23:0] ba);
		return ba[23:1];
	endfunction

	// mostly addresses inside a known region and some anywhere
	function automatic logic [ADDR_W-1:0] pick_addr();
		logic [31:0] r;
		int unsigned region;
		logic [23:0] ba;
		r      = $urandom();
		region = $urandom_range(7, 0);
		case (region)
			0: ba = {3'b000, r[20:0]};
			1: ba = {3'b110, r[20:0]};
			2: ba = {5'b11111, r[18:0]};
			3: ba = {8'hBF, r[15:0]};
			4: ba = {8'hDC, r[15:0]};
			5: ba = {12'hDFF, r[11:0]};
			default: ba = r[23:0];
		endcase
		return word_of(ba);
	endfunction

	task automatic drive_cpu(input logic [ADDR_W-1:0] a, input logic r,
			input logic h, input logic l);
		@(posedge clk);
		cpu <= '{addr: a, rd: r, hwr: h, lwr: l};
	endtask

	task automatic random_cycle();
		int unsigned op;
		logic [31:0] r;
		op = $urandom_range(3, 0);
		r  = $urandom();
		case (op)
			0, 1: drive_cpu(pick_addr(), 1'b1, 1'b0, 1'b0);
			2: drive_cpu(pick_addr(), 1'b0, 1'b1, 1'b1);
			default: drive_cpu(pick_addr(), 1'b0, r[0], ~r[0]);	// byte write
		endcase
	endtask

	task automatic pulse_sof();
		@(posedge clk);
		sof <= 1'b1;
		@(posedge clk);
		sof <= 1'b0;
		repeat (3) @(posedge clk);
	endtask

	task automatic wait_cpu_run(input int unsigned max_cycles);
		int unsigned n;
		for (n = 0; n < max_cycles && cpu_reset_n !== 1'b1; n++) begin
			@(posedge clk);
		end
		if (cpu_reset_n !== 1'b1) begin
			stop_on_error("cpu_reset_n was not released in time");
		end
	endtask

	// ------------------------------------------------------------------------
	// tests
	// ------------------------------------------------------------------------
	task automatic run_reset_seq();
		repeat (FRAME_COUNT) pulse_sof();
		wait_cpu_run(6);
		pulse_sof();	// no effect once running
		@(posedge clk);
		cpurst <= 1'b1;
		repeat (3) @(posedge clk);
		cpurst <= 1'b0;
		wait_cpu_run(6);
		cpu_reset_in_n <= 1'b0;	// reset instruction shows on sys_rst_out
		repeat (2) @(posedge clk);
		cpu_reset_in_n <= 1'b1;
		@(posedge clk);
		mrst <= 1'b1;
		@(posedge clk);
		mrst <= 1'b0;
		repeat (FRAME_COUNT) pulse_sof();
		wait_cpu_run(6);
	endtask

	task automatic run_overlay();
		mem_cfg <= 4'b11_00;	// 2 MB chip and no slow ram
		drive_cpu(word_of(24'h000000), 1'b1, 1'b0, 1'b0);	// rom vectors
		drive_cpu(word_of(24'h000000), 1'b0, 1'b1, 1'b1);
		drive_cpu(word_of(24'hF80010), 1'b0, 1'b1, 1'b1);
		drive_cpu(word_of(24'hBFE000), 1'b0, 1'b0, 1'b1);	// cia a write clears overlay
		drive_cpu(word_of(24'h000000), 1'b1, 1'b0, 1'b0);
		drive_cpu(word_of(24'hFC0000), 1'b0, 1'b1, 1'b0);
	endtask

	task automatic run_decode();
		for (int c = 0; c < 16; c++) begin
			mem_cfg <= 4'(c);
			repeat (PER_CFG) random_cycle();
		end
	endtask

	task automatic run_read_data();
		repeat (READ_CYC) begin
			mem_cfg      <= 4'($urandom());
			ram_rdata    <= 16'($urandom());
			cia_a_rdata  <= 8'($urandom());
			cia_b_rdata  <= 8'($urandom());
			custom_rdata <= 16'($urandom());
			rtc          <= {$urandom(), $urandom()};
			random_cycle();
		end
		drive_cpu(word_of(24'h000000), 1'b0, 1'b0, 1'b0);
	endtask

	task automatic run_interrupts();
		repeat (60) begin
			@(posedge clk);
			int_req <= 6'($urandom()) & 6'($urandom());	// sparse requests
		end
		for (int f = 0; f < 4; f++) begin
			@(posedge clk);
			freeze <= 1'b1;
			@(posedge clk);
			freeze <= 1'b0;
			repeat ($urandom_range(6, 2)) begin
				@(posedge clk);
				int_req <= 6'($urandom());
			end
			nmi_ack <= 1'b1;
			@(posedge clk);
			nmi_ack <= 1'b0;
			repeat (4) @(posedge clk);
		end
		@(posedge clk);
		freeze  <= 1'b1;	// strobe and ack together so freeze wins
		nmi_ack <= 1'b1;
		@(posedge clk);
		freeze  <= 1'b0;
		nmi_ack <= 1'b0;
		repeat (3) @(posedge clk);
		nmi_ack <= 1'b1;
		@(posedge clk);
		nmi_ack <= 1'b0;
		int_req <= '0;
	endtask

	// watchdog sized from the test lengths plus slack
	initial begin
		#(CLK_PERIOD * (TOTAL_CYC + 200));
		stop_on_error("watchdog expired before the tests finished");
	end

	initial begin
		void'($urandom(6));
		clk            = 1'b0;
		reset          <= 1'b1;
		cpu            <= '0;
		mem_cfg        <= '0;
		ram_rdata      <= '0;
		cia_a_rdata    <= '0;
		cia_b_rdata    <= '0;
		custom_rdata   <= '0;
		rtc            <= '0;
		int_req        <= '0;
		freeze         <= 1'b0;
		nmi_ack        <= 1'b0;
		sof            <= 1'b0;
		mrst           <= 1'b0;
		cpurst         <= 1'b0;
		cpu_reset_in_n <= 1'b1;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		run_reset_seq();
		run_overlay();
		run_decode();
		run_read_data();
		run_interrupts();
		repeat (4) @(posedge clk);
		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire
